// ==== tb/conv3x3_vectors.txt ====
# Two 5x5 frames in raster order, one pixel per line
# Columns: input pixel (hex), expected filtered output (hex)
10 09
10 0c
10 0c
10 0c
10 09
10 0c
10 10
10 10
10 10
10 0c
10 0c
10 10
10 10
10 10
10 0c
10 0c
10 10
10 10
10 10
10 0c
10 09
10 0c
10 0c
10 0c
10 09
00 03
10 0c
20 18
30 24
40 21
00 04
10 10
20 20
30 30
40 2c
00 04
10 10
20 20
30 30
40 2c
00 04
10 10
20 20
30 30
40 2c
00 03
10 0c
20 18
30 24
40 21

// ==== all.f ====
logic/filter_pkg.sv
logic/row_buffer.sv
logic/window_3x3.sv
logic/kernel_mac.sv
logic/frame_sequencer.sv
logic/conv3x3_top.sv
tb/conv3x3_assertions.sv
tb/conv3x3_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the conv3x3 testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module conv3x3_tb -f all.f -o conv3x3_sim; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/conv3x3_sim > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation exited with an error"
  exit 1
fi

cat "$LOG"

if grep -q "SIMULATION PASSED" "$LOG"; then
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi

// ==== tb/conv3x3_tb.sv ====
`timescale 1ns/1ps

module conv3x3_tb;
  import filter_pkg::*;

  localparam int MAX_VEC = 64;

  logic clk;
  logic rst_n;
  logic i_pix_valid;
  logic o_pix_ready;
  pix_t i_pix;
  logic o_out_valid;
  logic i_out_ready;
  pix_t o_out_pix;
  logic o_out_last;

  pix_t in_pix  [MAX_VEC];
  pix_t exp_pix [MAX_VEC];
  int   n_vec;
  int   out_count;
  int   errors;
  int   seed;
  int   bp_seed;
  bit   vec_loaded;
  bit   bp_on;

  conv3x3_top dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_pix_valid (i_pix_valid),
    .o_pix_ready (o_pix_ready),
    .i_pix       (i_pix),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready),
    .o_out_pix   (o_out_pix),
    .o_out_last  (o_out_last)
  );

  always #20 clk = ~clk;

  task automatic check_value(input string name, input int idx, input int expected,
                             input int actual);
    if (expected !== actual) begin
      $display("FAILED %s[%0d] expected %0d actual %0d", name, idx, expected, actual);
      errors++;
    end
  endtask

  task automatic read_vectors();
    int    fd;
    int    n;
    int    a;
    int    b;
    string line;
    fd = $fopen("tb/conv3x3_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != 8'h23 && n_vec < MAX_VEC) begin
          n = $sscanf(line, "%h %h", a, b);
          if (n == 2) begin
            in_pix[n_vec]  = pix_t'(a);
            exp_pix[n_vec] = pix_t'(b);
            n_vec++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Starts and ends 2 ns after a rising edge
  task automatic send_pixel(input pix_t value, input bit gaps);
    int idle;
    bit accepted;
    idle = gaps ? ($random(seed) & 3) : 0;
    repeat (idle) begin
      @(posedge clk);
      #2;
    end
    i_pix_valid = 1'b1;
    i_pix       = value;
    accepted    = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = o_pix_ready;
      @(posedge clk);
      #2;
    end
    i_pix_valid = 1'b0;
  endtask

  // Random back-pressure once the second frame starts
  always @(posedge clk) begin
    #2;
    i_out_ready = bp_on ? (($random(bp_seed) & 3) != 0) : 1'b1;
  end

  // ====================
  // Output checking
  // ====================

  always @(negedge clk) begin
    if (rst_n && o_out_valid && i_out_ready) begin
      if (out_count >= n_vec) begin
        $display("Output %0d arrived after all expected outputs", out_count);
        errors++;
      end else begin
        check_value("pixel", out_count, exp_pix[out_count], o_out_pix);
        check_value("last", out_count, (out_count % FRAME_PIXELS) == FRAME_PIXELS - 1,
                    o_out_last);
      end
      out_count++;
    end
  end

  initial begin
    wait (vec_loaded);
    #(40 * (n_vec * 8 + 200));
    $display("The run timed out with %0d of %0d outputs seen", out_count, n_vec);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    i_pix_valid = 1'b0;
    i_pix       = '0;
    i_out_ready = 1'b1;
    n_vec       = 0;
    out_count   = 0;
    errors      = 0;
    seed        = 43451;
    bp_seed     = seed + 1;
    bp_on       = 1'b0;
    vec_loaded  = 1'b0;
    read_vectors();
    vec_loaded = 1'b1;

    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("reset_out_valid", 0, 0, o_out_valid);
    check_value("reset_pix_ready", 0, 1, o_pix_ready);
    @(posedge clk);
    #2;

    // Frame 1 streams without gaps
    for (int i = 0; i < FRAME_PIXELS && i < n_vec; i++) begin
      send_pixel(in_pix[i], 1'b0);
    end
    @(negedge clk);
    check_value("flush_pix_ready", 0, 0, o_pix_ready);
    @(posedge clk);
    #2;

    bp_on = 1'b1;
    for (int i = FRAME_PIXELS; i < n_vec; i++) begin
      send_pixel(in_pix[i], 1'b1);
    end

    wait (out_count >= n_vec);
    repeat (40) @(posedge clk);
    if (n_vec != 2 * FRAME_PIXELS) begin
      $display("Vector file held %0d entries instead of %0d", n_vec, 2 * FRAME_PIXELS);
      errors++;
    end

    $display("Outputs: %0d of %0d, errors: %0d", out_count, n_vec, errors);
    if (errors == 0 && out_count == n_vec) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/conv3x3_assertions.sv ====
`timescale 1ns/1ps

module conv3x3_assertions (
  input logic             clk,
  input logic             rst_n,
  input logic             i_pix_valid,
  input logic             o_out_valid,
  input logic             i_out_ready,
  input filter_pkg::pix_t o_out_pix,
  input logic             o_out_last,
  input logic             o_pix_ready,
  input logic             i_step_en
);
  import filter_pkg::*;

  int in_cnt;
  int flush_left;

  // Accepted pixels of the current frame, and zero steps still owed after it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_cnt     <= 0;
      flush_left <= 0;
    end else if (i_pix_valid && o_pix_ready) begin
      if (in_cnt == FRAME_PIXELS - 1) begin
        in_cnt     <= 0;
        flush_left <= FLUSH_STEPS;
      end else begin
        in_cnt <= in_cnt + 1;
      end
    end else if (i_step_en && flush_left > 0) begin
      flush_left <= flush_left - 1;
    end
  end

  // A stalled output keeps its pixel and last flag
  out_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    (o_out_valid && !i_out_ready) |=> (o_out_valid && $stable(o_out_pix) && $stable(o_out_last)))
    else $error("Output changed while stalled");

  flush_ready_a: assert property (@(posedge clk) disable iff (!rst_n)
    (flush_left > 0) |-> !o_pix_ready)
    else $error("Input ready during flush");

  reset_valid_a: assert property (@(posedge clk)
    !rst_n |=> !o_out_valid)
    else $error("Output valid right after reset");

endmodule

bind conv3x3_top conv3x3_assertions assert_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .i_pix_valid (i_pix_valid),
  .o_out_valid (o_out_valid),
  .i_out_ready (i_out_ready),
  .o_out_pix   (o_out_pix),
  .o_out_last  (o_out_last),
  .o_pix_ready (o_pix_ready),
  .i_step_en   (step_en)
);

// ==== logic/conv3x3_top.sv ====
`timescale 1ns/1ps

module conv3x3_top (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             i_pix_valid,
  output logic             o_pix_ready,
  input  filter_pkg::pix_t i_pix,
  output logic             o_out_valid,
  input  logic             i_out_ready,
  output filter_pkg::pix_t o_out_pix,
  output logic             o_out_last
);
  import filter_pkg::*;

  logic step_en;
  logic emit_en;
  logic frame_last_step;
  logic out_free;
  logic win_valid;
  logic win_last;
  pix_t step_pix;
  pix_t tap_top;
  pix_t tap_mid;
  pix_t tap_bot;
  pix_t win0;
  pix_t win1;
  pix_t win2;
  pix_t win3;
  pix_t win4;
  pix_t win5;
  pix_t win6;
  pix_t win7;
  pix_t win8;

  frame_sequencer seq_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .i_pix_valid       (i_pix_valid),
    .i_pix             (i_pix),
    .o_pix_ready       (o_pix_ready),
    .i_out_free        (out_free),
    .o_step_en         (step_en),
    .o_step_pix        (step_pix),
    .o_emit_en         (emit_en),
    .o_frame_last_step (frame_last_step)
  );

  row_buffer rows_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_step_en (step_en),
    .i_pix     (step_pix),
    .o_tap_top (tap_top),
    .o_tap_mid (tap_mid),
    .o_tap_bot (tap_bot)
  );

  window_3x3 win_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .i_step_en         (step_en),
    .i_emit_en         (emit_en),
    .i_frame_last_step (frame_last_step),
    .i_tap_top         (tap_top),
    .i_tap_mid         (tap_mid),
    .i_tap_bot         (tap_bot),
    .o_win0            (win0),
    .o_win1            (win1),
    .o_win2            (win2),
    .o_win3            (win3),
    .o_win4            (win4),
    .o_win5            (win5),
    .o_win6            (win6),
    .o_win7            (win7),
    .o_win8            (win8),
    .o_win_valid       (win_valid),
    .o_win_last        (win_last)
  );

  kernel_mac mac_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_step_en   (step_en),
    .i_win0      (win0),
    .i_win1      (win1),
    .i_win2      (win2),
    .i_win3      (win3),
    .i_win4      (win4),
    .i_win5      (win5),
    .i_win6      (win6),
    .i_win7      (win7),
    .i_win8      (win8),
    .i_win_valid (win_valid),
    .i_win_last  (win_last),
    .i_out_ready (i_out_ready),
    .o_out_free  (out_free),
    .o_out_valid (o_out_valid),
    .o_out_pix   (o_out_pix),
    .o_out_last  (o_out_last)
  );

endmodule

// ==== logic/frame_sequencer.sv ====
`timescale 1ns/1ps

module frame_sequencer (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             i_pix_valid,
  input  filter_pkg::pix_t i_pix,
  output logic             o_pix_ready,
  input  logic             i_out_free,
  output logic             o_step_en,
  output filter_pkg::pix_t o_step_pix,
  output logic             o_emit_en,
  output logic             o_frame_last_step
);
  import filter_pkg::*;

  logic                   flushing;
  logic [PIX_CNT_W-1:0]   pix_cnt;
  logic [FLUSH_CNT_W-1:0] flush_cnt;
  logic                   pix_last;
  logic                   flush_last;

  assign pix_last   = (pix_cnt == PIX_CNT_W'(FRAME_PIXELS - 1));
  assign flush_last = (flush_cnt == FLUSH_CNT_W'(FLUSH_STEPS - 1));

  // ====================
  // Step control
  // ====================

  // Nothing moves while the output register holds an untaken pixel
  assign o_pix_ready = ~flushing & i_out_free;
  assign o_step_en   = i_out_free & (flushing | i_pix_valid);
  assign o_step_pix  = flushing ? '0 : i_pix;

  // The first FLUSH_STEPS input steps only fill the row buffer and window
  assign o_emit_en         = flushing | (pix_cnt >= PIX_CNT_W'(FLUSH_STEPS));
  assign o_frame_last_step = flushing & flush_last;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flushing  <= 1'b0;
      pix_cnt   <= '0;
      flush_cnt <= '0;
    end else if (o_step_en) begin
      if (flushing) begin
        if (flush_last) begin
          flushing  <= 1'b0;
          flush_cnt <= '0;
        end else begin
          flush_cnt <= flush_cnt + 1'b1;
        end
      end else begin
        if (pix_last) begin
          flushing <= 1'b1;
          pix_cnt  <= '0;
        end else begin
          pix_cnt <= pix_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// ==== logic/kernel_mac.sv ====
`timescale 1ns/1ps

module kernel_mac (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             i_step_en,
  input  filter_pkg::pix_t i_win0,
  input  filter_pkg::pix_t i_win1,
  input  filter_pkg::pix_t i_win2,
  input  filter_pkg::pix_t i_win3,
  input  filter_pkg::pix_t i_win4,
  input  filter_pkg::pix_t i_win5,
  input  filter_pkg::pix_t i_win6,
  input  filter_pkg::pix_t i_win7,
  input  filter_pkg::pix_t i_win8,
  input  logic             i_win_valid,
  input  logic             i_win_last,
  input  logic             i_out_ready,
  output logic             o_out_free,
  output logic             o_out_valid,
  output filter_pkg::pix_t o_out_pix,
  output logic             o_out_last
);
  import filter_pkg::*;

  logic [SUM_W-1:0] weighted;
  logic             win_fresh;
  logic             load;

  // 1-2-1 / 2-4-2 / 1-2-1 weights
  assign weighted = SUM_W'(i_win0) + (SUM_W'(i_win1) << 1) + SUM_W'(i_win2)
                  + (SUM_W'(i_win3) << 1) + (SUM_W'(i_win4) << 2) + (SUM_W'(i_win5) << 1)
                  + SUM_W'(i_win6) + (SUM_W'(i_win7) << 1) + SUM_W'(i_win8);

  assign o_out_free = ~o_out_valid | i_out_ready;

  // Window content is consumed once, either at the next step or as soon as the
  // output register has room, which also drains the last window of a frame
  assign load = o_out_free & win_fresh & i_win_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_fresh <= 1'b0;
    end else if (i_step_en) begin
      win_fresh <= 1'b1;
    end else if (load) begin
      win_fresh <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_out_valid <= 1'b0;
    end else if (load) begin
      o_out_valid <= 1'b1;
    end else if (i_out_ready) begin
      o_out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      o_out_pix  <= weighted[KERNEL_SHIFT +: PIX_W];
      o_out_last <= i_win_last;
    end
  end

endmodule

// ==== logic/window_3x3.sv ====
`timescale 1ns/1ps

module window_3x3 (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             i_step_en,
  input  logic             i_emit_en,
  input  logic             i_frame_last_step,
  input  filter_pkg::pix_t i_tap_top,
  input  filter_pkg::pix_t i_tap_mid,
  input  filter_pkg::pix_t i_tap_bot,
  output filter_pkg::pix_t o_win0,
  output filter_pkg::pix_t o_win1,
  output filter_pkg::pix_t o_win2,
  output filter_pkg::pix_t o_win3,
  output filter_pkg::pix_t o_win4,
  output filter_pkg::pix_t o_win5,
  output filter_pkg::pix_t o_win6,
  output filter_pkg::pix_t o_win7,
  output filter_pkg::pix_t o_win8,
  output logic             o_win_valid,
  output logic             o_win_last
);
  import filter_pkg::*;

  // Two older columns per row, index 1/3/5 is the newer one
  pix_t shift_q  [6];
  pix_t win_next [9];

  logic [ROW_W-1:0] row;
  logic [COL_W-1:0] col;

  logic top_edge;
  logic bot_edge;
  logic left_edge;
  logic right_edge;
  logic emit;

  assign emit       = i_step_en & i_emit_en;
  assign top_edge   = (row == '0);
  assign bot_edge   = (row == ROW_W'(FRAME_ROWS - 1));
  assign left_edge  = (col == '0);
  assign right_edge = (col == COL_W'(FRAME_COLS - 1));

  // ====================
  // Centre position
  // ====================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row <= '0;
      col <= '0;
    end else if (emit) begin
      if (right_edge) begin
        col <= '0;
        row <= bot_edge ? '0 : row + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 6; i++) begin
        shift_q[i] <= '0;
      end
    end else if (i_step_en) begin
      shift_q[0] <= shift_q[1];
      shift_q[1] <= i_tap_top;
      shift_q[2] <= shift_q[3];
      shift_q[3] <= i_tap_mid;
      shift_q[4] <= shift_q[5];
      shift_q[5] <= i_tap_bot;
    end
  end

  // The window is taken after this step's shift, with taps outside the frame cleared
  always_comb begin
    win_next[0] = (top_edge | left_edge)  ? '0 : shift_q[0];
    win_next[1] = top_edge                ? '0 : shift_q[1];
    win_next[2] = (top_edge | right_edge) ? '0 : i_tap_top;
    win_next[3] = left_edge               ? '0 : shift_q[2];
    win_next[4] = shift_q[3];
    win_next[5] = right_edge              ? '0 : i_tap_mid;
    win_next[6] = (bot_edge | left_edge)  ? '0 : shift_q[4];
    win_next[7] = bot_edge                ? '0 : shift_q[5];
    win_next[8] = (bot_edge | right_edge) ? '0 : i_tap_bot;
  end

  // ====================
  // Window output
  // ====================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_win0      <= '0;
      o_win1      <= '0;
      o_win2      <= '0;
      o_win3      <= '0;
      o_win4      <= '0;
      o_win5      <= '0;
      o_win6      <= '0;
      o_win7      <= '0;
      o_win8      <= '0;
      o_win_valid <= 1'b0;
      o_win_last  <= 1'b0;
    end else if (i_step_en) begin
      o_win_valid <= i_emit_en;
      o_win_last  <= i_emit_en & i_frame_last_step;
      if (i_emit_en) begin
        o_win0 <= win_next[0];
        o_win1 <= win_next[1];
        o_win2 <= win_next[2];
        o_win3 <= win_next[3];
        o_win4 <= win_next[4];
        o_win5 <= win_next[5];
        o_win6 <= win_next[6];
        o_win7 <= win_next[7];
        o_win8 <= win_next[8];
      end
    end
  end

endmodule

// ==== logic/row_buffer.sv ====
`timescale 1ns/1ps

module row_buffer (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             i_step_en,
  input  filter_pkg::pix_t i_pix,
  output filter_pkg::pix_t o_tap_top,
  output filter_pkg::pix_t o_tap_mid,
  output filter_pkg::pix_t o_tap_bot
);
  import filter_pkg::*;

  // Each line delays the stream by exactly one frame row
  pix_t line_mid [FRAME_COLS];
  pix_t line_top [FRAME_COLS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < FRAME_COLS; i++) begin
        line_mid[i] <= '0;
        line_top[i] <= '0;
      end
    end else if (i_step_en) begin
      line_mid[0] <= i_pix;
      line_top[0] <= line_mid[FRAME_COLS-1];
      for (int i = 1; i < FRAME_COLS; i++) begin
        line_mid[i] <= line_mid[i-1];
        line_top[i] <= line_top[i-1];
      end
    end
  end

  // The bottom tap is the pixel of the current step itself
  assign o_tap_bot = i_pix;
  assign o_tap_mid = line_mid[FRAME_COLS-1];
  assign o_tap_top = line_top[FRAME_COLS-1];

endmodule

// ==== logic/filter_pkg.sv ====
package filter_pkg;

  // ====================
  // Frame geometry
  // ====================

  localparam int FRAME_ROWS = 5;
  localparam int FRAME_COLS = 5;
  localparam int FRAME_PIXELS = FRAME_ROWS * FRAME_COLS;

  // Zero steps after the last pixel push the bottom row and right column out
  localparam int FLUSH_STEPS = FRAME_COLS + 1;

  localparam int ROW_W = $clog2(FRAME_ROWS);
  localparam int COL_W = $clog2(FRAME_COLS);
  localparam int PIX_CNT_W = $clog2(FRAME_PIXELS);
  localparam int FLUSH_CNT_W = $clog2(FLUSH_STEPS);

  // ====================
  // Datapath widths
  // ====================

  localparam int PIX_W = 8;

  // Kernel weights add up to 16, so the sum needs 4 bits above the pixel
  localparam int SUM_W = 12;
  localparam int KERNEL_SHIFT = 4;

  typedef logic [PIX_W-1:0] pix_t;

endpackage
